/* include/button_fifo_params.svh */
`ifndef BUTTON_FIFO_PARAMS_SVH
`define BUTTON_FIFO_PARAMS_SVH

// width of one stored word, as set on the switches.
`define BF_DATA_BITS 8

// fifo address width, 2**3 gives 8 entries.
`define BF_ADDR_BITS 3

// consecutive stable samples before a new button level is taken.
`define BF_DEBOUNCE_CYCLES 4

`endif

/* source/button_fifo_pkg.sv */
`include "button_fifo_params.svh"

package button_fifo_pkg;

  // ##################################################
  // data
  // ##################################################

  // one word from the switches.
  typedef logic [`BF_DATA_BITS-1:0] data_t;

  // ##################################################
  // control and status
  // ##################################################

  // single-cycle command strobes from the button front end.
  // wr and rd are never high in the same cycle.
  typedef struct packed {
    logic wr;
    logic rd;
  } button_cmd_t;

  // registered fifo flags.
  typedef struct packed {
    logic empty;
    logic full;
  } fifo_status_t;

endpackage

/* source/key_command.sv */
`timescale 1ns/1ps

`include "button_fifo_params.svh"

module key_command
(
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      wr_button,
  input  logic                      rd_button,
  output button_fifo_pkg::button_cmd_t cmd,
  output logic                      ready
);

  // bit positions of the two buttons in the vectors below.
  localparam int wr_idx = 0;
  localparam int rd_idx = 1;

  localparam int cnt_bits = $clog2(`BF_DEBOUNCE_CYCLES + 1);

  // the sample that completes a run of stable values.
  localparam logic [cnt_bits-1:0] cnt_last = cnt_bits'(`BF_DEBOUNCE_CYCLES - 1);

  logic [1:0]          btn_in;
  logic [1:0]          sync_a;
  logic [1:0]          sync_b;
  logic [1:0]          level;
  logic [1:0]          level_d;
  logic [1:0]          rise;
  logic [cnt_bits-1:0] count [2];

  assign btn_in[wr_idx] = wr_button;
  assign btn_in[rd_idx] = rd_button;

  // ##################################################
  // synchronizers
  // ##################################################

  // two flops per button, the buttons are asynchronous to clock.
  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      sync_a <= '0;
      sync_b <= '0;
    end
    else
    begin
      sync_a <= btn_in;
      sync_b <= sync_a;
    end
  end

  // ##################################################
  // debounce
  // ##################################################

  // a new level is accepted only after cnt_last + 1 samples that
  // all differ from the current one; any agreeing sample restarts.
  for (genvar i = 0; i < 2; i++)
  begin : g_debounce
    always_ff @(posedge clock or posedge reset)
    begin
      if (reset)
      begin
        count[i] <= '0;
        level[i] <= 1'b0;
      end
      else if (sync_b[i] == level[i])
      begin
        count[i] <= '0;
      end
      else if (count[i] == cnt_last)
      begin
        level[i] <= sync_b[i];
        count[i] <= '0;
      end
      else
      begin
        count[i] <= count[i] + cnt_bits'(1);
      end
    end
  end

  // previous accepted level, for edge detection.
  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      level_d <= '0;
    end
    else
    begin
      level_d <= level;
    end
  end

  // ##################################################
  // command strobes
  // ##################################################

  assign rise = level & ~level_d;

  // a press only counts while the other button is released.
  // both rising together blocks both, and neither can fire again
  // until its own level has gone low and risen once more.
  always_comb
  begin
    cmd.wr = rise[wr_idx] & ~level[rd_idx];
    cmd.rd = rise[rd_idx] & ~level[wr_idx];
  end

  // board is out of reset from the first edge after release.
  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      ready <= 1'b0;
    end
    else
    begin
      ready <= 1'b1;
    end
  end

endmodule

/* source/fifo_core.sv */
`timescale 1ns/1ps

`include "button_fifo_params.svh"

module fifo_core
#(
  parameter type payload_t = button_fifo_pkg::data_t
)
(
  input  logic                          clock,
  input  logic                          reset,
  input  button_fifo_pkg::button_cmd_t  cmd,
  input  payload_t                      din,
  output payload_t                      dout,
  output logic                          dout_valid,
  output button_fifo_pkg::fifo_status_t status
);

  localparam int addr_bits = `BF_ADDR_BITS;
  localparam int depth     = 2 ** addr_bits;

  payload_t mem [depth];

  logic [addr_bits-1:0] wr_ptr;
  logic [addr_bits-1:0] wr_next;
  logic [addr_bits-1:0] wr_succ;
  logic [addr_bits-1:0] rd_ptr;
  logic [addr_bits-1:0] rd_next;
  logic [addr_bits-1:0] rd_succ;

  button_fifo_pkg::fifo_status_t flags;
  button_fifo_pkg::fifo_status_t flags_next;

  logic wr_en;
  logic rd_en;

  // commands against a full or empty fifo are simply dropped.
  assign wr_en = cmd.wr & ~flags.full;
  assign rd_en = cmd.rd & ~flags.empty;

  // ##################################################
  // next state
  // ##################################################

  always_comb
  begin
    wr_succ    = wr_ptr + addr_bits'(1);
    rd_succ    = rd_ptr + addr_bits'(1);
    wr_next    = wr_ptr;
    rd_next    = rd_ptr;
    flags_next = flags;

    case ({wr_en, rd_en})
      2'b10:
      begin
        wr_next          = wr_succ;
        flags_next.empty = 1'b0;
        // full once every slot holds a word.
        if (wr_succ == rd_ptr)
        begin
          flags_next.full = 1'b1;
        end
      end
      2'b01:
      begin
        rd_next         = rd_succ;
        flags_next.full = 1'b0;
        if (rd_succ == wr_ptr)
        begin
          flags_next.empty = 1'b1;
        end
      end
      2'b11:
      begin
        // occupancy does not change, so neither flag can.
        wr_next = wr_succ;
        rd_next = rd_succ;
      end
      default:
      begin
        // nothing moves without a command.
      end
    endcase
  end

  // ##################################################
  // registers
  // ##################################################

  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      flags      <= '{empty: 1'b1, full: 1'b0};
      dout_valid <= 1'b0;
    end
    else
    begin
      wr_ptr     <= wr_next;
      rd_ptr     <= rd_next;
      flags      <= flags_next;
      dout_valid <= rd_en;
    end
  end

  // storage.
  always_ff @(posedge clock)
  begin
    if (wr_en)
    begin
      mem[wr_ptr] <= din;
    end
  end

  // the oldest word stays here until the next successful read.
  always_ff @(posedge clock)
  begin
    if (rd_en)
    begin
      dout <= mem[rd_ptr];
    end
  end

  assign status = flags;

endmodule

/* source/button_fifo_top.sv */
`timescale 1ns/1ps

module button_fifo_top
(
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          wr_button,
  input  logic                          rd_button,
  input  button_fifo_pkg::data_t        din,
  output button_fifo_pkg::data_t        dout,
  output logic                          dout_valid,
  output button_fifo_pkg::fifo_status_t status,
  output logic                          ready
);

  // exclusive single-cycle strobes from the buttons.
  button_fifo_pkg::button_cmd_t cmd;

  // ##################################################
  // button front end
  // ##################################################

  key_command u_key_command
  (
    .clock     (clock),
    .reset     (reset),
    .wr_button (wr_button),
    .rd_button (rd_button),
    .cmd       (cmd),
    .ready     (ready)
  );

  // ##################################################
  // fifo
  // ##################################################

  fifo_core
  #(
    .payload_t (button_fifo_pkg::data_t)
  )
  u_fifo_core
  (
    .clock      (clock),
    .reset      (reset),
    .cmd        (cmd),
    .din        (din),
    .dout       (dout),
    .dout_valid (dout_valid),
    .status     (status)
  );

endmodule

/* sim/button_fifo_asserts.sv */
`timescale 1ns/1ps

module button_fifo_asserts
(
  input logic                          clock,
  input logic                          reset,
  input button_fifo_pkg::button_cmd_t  cmd,
  input logic                          dout_valid,
  input button_fifo_pkg::fifo_status_t status
);

  // a fifo cannot be full and empty at once.
  flags_exclusive: assert property (@(posedge clock) disable iff (reset)
    !(status.empty && status.full))
  else $error("fifo reports full and empty in the same cycle");

  // reads are whole presses apart, so a valid strobe never repeats.
  valid_single: assert property (@(posedge clock) disable iff (reset)
    dout_valid |=> !dout_valid)
  else $error("dout_valid held for more than one cycle");

  // the front end never issues both commands together.
  cmd_exclusive: assert property (@(posedge clock) disable iff (reset)
    !(cmd.wr && cmd.rd))
  else $error("write and read commands in the same cycle");

endmodule

bind fifo_core button_fifo_asserts u_asserts
(
  .clock      (clock),
  .reset      (reset),
  .cmd        (cmd),
  .dout_valid (dout_valid),
  .status     (status)
);

/* sim/button_fifo_tb.sv */
`timescale 1ns/1ps

`include "button_fifo_params.svh"

module button_fifo_tb;

  localparam int depth          = 2 ** `BF_ADDR_BITS;
  localparam int wait_limit     = 40;
  localparam int release_cycles = 12;

  logic                          clock;
  logic                          reset;
  logic                          wr_button;
  logic                          rd_button;
  button_fifo_pkg::data_t        din;
  button_fifo_pkg::data_t        dout;
  logic                          dout_valid;
  button_fifo_pkg::fifo_status_t status;
  logic                          ready;

  // reference contents, front entry is the oldest word.
  button_fifo_pkg::data_t model [$];
  button_fifo_pkg::data_t last_dout;
  int pulses;
  int value_errors;
  int other_errors;

  button_fifo_top UUT
  (
    .clock      (clock),
    .reset      (reset),
    .wr_button  (wr_button),
    .rd_button  (rd_button),
    .din        (din),
    .dout       (dout),
    .dout_valid (dout_valid),
    .status     (status),
    .ready      (ready)
  );

  always #50 clock = ~clock;

  // ##################################################
  // helpers
  // ##################################################

  // outputs only move on the rising edge, so the falling edge is safe.
  task automatic step();
    @(negedge clock);
    if (dout_valid)
    begin
      pulses++;
      last_dout = dout;
    end
  endtask

  task automatic compare(input string name, input logic [7:0] expected,
                         input logic [7:0] actual);
    if (actual !== expected)
    begin
      $display("** Error %s: expected %h, actual %h", name, expected, actual);
      value_errors++;
    end
  endtask

  // hold the buttons, then release; a watched press ends early on dout_valid.
  task automatic press(input logic wr, input logic rd, input int hold,
                       input logic watch);
    int cyc;
    int limit;
    limit     = watch ? wait_limit : hold;
    pulses    = 0;
    wr_button = wr;
    rd_button = rd;
    cyc       = 0;
    while (cyc < limit && !(watch && pulses != 0))
    begin
      if (cyc == hold)
      begin
        wr_button = 1'b0;
        rd_button = 1'b0;
      end
      step();
      cyc++;
    end
    wr_button = 1'b0;
    rd_button = 1'b0;
    repeat (release_cycles) step();
  endtask

  // ##################################################
  // main sequence
  // ##################################################

  initial
  begin
    int fd;
    int lineno;
    int fields;
    int hold;
    string line;
    string name;
    logic [7:0] op;
    button_fifo_pkg::data_t data;
    button_fifo_pkg::data_t expected;

    clock        = 1'b0;
    reset        = 1'b1;
    wr_button    = 1'b0;
    rd_button    = 1'b0;
    din          = '0;
    pulses       = 0;
    value_errors = 0;
    other_errors = 0;
    lineno       = 0;

    repeat (5) @(negedge clock);
    compare("reset ready", 8'h00, 8'(ready));
    compare("reset status", 8'h02, 8'({status.empty, status.full}));
    compare("reset dout_valid", 8'h00, 8'(dout_valid));
    reset = 1'b0;
    step();
    compare("ready after reset", 8'h01, 8'(ready));

    fd = $fopen("sim/button_fifo_golden.txt", "r");
    if (fd == 0)
    begin
      $display("could not open the golden file");
      other_errors++;
    end
    else
    begin
      while ($fgets(line, fd) != 0)
      begin
        lineno++;
        fields = $sscanf(line, "%s %d %h", op, hold, data);
        if (line.len() == 0 || line[0] == "#" || fields != 3)
        begin
          continue;
        end
        name = $sformatf("%s line %0d", op, lineno);
        case (op)
          "W":
          begin
            din = data;
            press(1'b1, 1'b0, hold, 1'b0);
            // a write into a full fifo is dropped.
            if (model.size() < depth)
            begin
              model.push_back(data);
            end
          end
          "R":
          begin
            if (model.size() == 0)
            begin
              press(1'b0, 1'b1, hold, 1'b1);
              if (pulses != 0)
              begin
                $display("%s: dout_valid after a read from an empty fifo", name);
                other_errors++;
              end
            end
            else
            begin
              expected = model.pop_front();
              if (data != expected)
              begin
                $display("%s: golden file disagrees with the fifo model", name);
                other_errors++;
              end
              press(1'b0, 1'b1, hold, 1'b1);
              if (pulses == 0)
              begin
                $display("%s: timed out waiting for dout_valid", name);
                other_errors++;
              end
              else
              begin
                if (pulses > 1)
                begin
                  $display("%s: more than one dout_valid pulse for one read", name);
                  other_errors++;
                end
                compare(name, expected, last_dout);
              end
            end
          end
          "B":
          begin
            press(1'b1, 1'b1, hold, 1'b0);
          end
          "G":
          begin
            press(1'b1, 1'b0, hold, 1'b0);
          end
          default:
          begin
            $display("unknown operation at line %0d", lineno);
            other_errors++;
          end
        endcase
        if (op != "R" && pulses != 0)
        begin
          $display("%s: dout_valid without a read", name);
          other_errors++;
        end
        compare({name, " status"}, 8'({model.size() == 0, model.size() == depth}),
                8'({status.empty, status.full}));
        compare({name, " ready"}, 8'h01, 8'(ready));
      end
      $fclose(fd);
    end

    $display("errors: %0d value, %0d other", value_errors, other_errors);
    if (value_errors + other_errors == 0)
    begin
      $display("test passed");
    end
    else
    begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* sim/button_fifo_golden.txt */
# op hold data: W writes data, R expects data at dout (unused when empty)
# B presses both buttons, G glitches the write button; data unused there
W 8 11
W 8 22
W 9 33
R 8 11
B 8 00
G 3 00
R 8 22
R 10 33
R 8 00
W 8 a1
W 8 a2
W 8 a3
W 8 a4
W 8 a5
W 8 a6
W 8 a7
W 8 a8
W 8 ff
R 8 a1
W 8 b1
R 8 a2
R 8 a3
R 8 a4
R 8 a5
R 8 a6
R 8 a7
R 8 a8
R 8 b1
R 8 00

/* verilog.f */
+incdir+include
source/button_fifo_pkg.sv
source/key_command.sv
source/fifo_core.sv
source/button_fifo_top.sv
sim/button_fifo_asserts.sv
sim/button_fifo_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the testbench with verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f \
  --top-module button_fifo_tb -o button_fifo_sim
rc=$?
if [ $rc -ne 0 ]; then
  echo "verilator build failed with status $rc"
  exit 1
fi

output=$(./obj_dir/button_fifo_sim)
rc=$?
printf '%s\n' "$output"
if [ $rc -ne 0 ]; then
  echo "simulation exited with status $rc"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "test passed"; then
  exit 0
fi

echo "simulation did not report a pass"
exit 1
